/* sources.f */
+incdir+.
rx_pkg.sv
deser_bitslip.sv
word_align_fsm.sv
dec_8b10b.sv
serial_rx.sv
tb_clock_gen.sv
serial_rx_checker.sv
tb_serial_rx.sv

/* Bender.yml */
package:
  name: serial_rx

sources:
  - files:
      - rx_pkg.sv
      - deser_bitslip.sv
      - word_align_fsm.sv
      - dec_8b10b.sv
      - serial_rx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - serial_rx_checker.sv
      - tb_serial_rx.sv

/* tb_8b10b_model.svh */
`ifndef TB_8B10B_MODEL_SVH
`define TB_8B10B_MODEL_SVH

// 5b/6b codes in their RD- form as abcdei with a at the msb
function automatic logic [5:0] code6_neg(input logic [4:0] x);
    logic [5:0] t [32];
    t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001,
          6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100,
          6'b011100, 6'b010111, 6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011,
          6'b101010, 6'b011010, 6'b111010, 6'b110011, 6'b100110, 6'b010110, 6'b110110,
          6'b001110, 6'b101110, 6'b011110, 6'b101011};
    return t[x];
endfunction

// 3b/4b codes in their RD- form as fghj with f at the msb
function automatic logic [3:0] code4_neg(input logic [2:0] y);
    logic [3:0] t [8];
    t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
    return t[y];
endfunction

// rd of 1 means positive running disparity
function automatic rx_pkg::word_t encode_8b10b(input rx_pkg::byte_t d, input logic k,
                                               input logic rd_in, output logic rd_out);
    logic [4:0] x;
    logic [2:0] y;
    logic [5:0] s6;
    logic [3:0] s4;
    logic       rd_mid;
    logic       k28;
    logic       use_a7;
    rx_pkg::word_t w;
    x   = d[4:0];
    y   = d[7:5];
    k28 = k && (x == 5'd28);
    s6  = k28 ? 6'b001111 : code6_neg(x);
    rd_mid = k28 ? 1'b0 : rd_in;   // K28 is built in its RD- form and inverted whole
    if (rd_mid && ($countones(s6) != 3 || x == 5'd7))
        s6 = ~s6;
    if ($countones(s6) != 3)
        rd_mid = ~rd_mid;
    use_a7 = (y == 3'd7) && (k || (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20))
                              || (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
    s4 = use_a7 ? 4'b0111 : code4_neg(y);
    if (rd_mid && ($countones(s4) != 2 || y == 3'd3))
        s4 = ~s4;
    w = {s6, s4};
    if (k28 && rd_in)
        w = ~w;
    rd_out = rd_in ^ ($countones(w[9:4]) != 3) ^ ($countones(w[3:0]) != 2);
    return w;
endfunction

`endif

/* tb_serial_rx.sv */
`timescale 1ns/1ps

module tb_serial_rx;

    localparam real period_ns      = 4.0;
    localparam int  reset_cycles   = 16;
    localparam int  data_words     = 280;   // 200 + 40 + 40
    localparam int  max_lock_words = 48;    // 10 slips x 4 words, with margin
    localparam int  timeout_cycles = ((2 * data_words + 3 * max_lock_words + 8) * 10
                                      + 3 * 10 * 4 * 10) * 2 + 100;
    localparam rx_pkg::byte_t k28_1 = 8'h3C;

    logic          FCLK;
    logic          reset;
    logic          serial_in;
    rx_pkg::byte_t rx_data;
    logic          rx_k;
    logic          rx_valid;
    logic          rx_err;
    logic          locked;

    integer        seed;
    logic          tx_rd;
    logic [8:0]    exp_q [$];   // {k, byte}
    int            errs_expected;
    int            cycle_cnt;

    `include "tb_8b10b_model.svh"

    tb_clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) clk_i (
        .FCLK  (FCLK),
        .reset (reset)
    );

    serial_rx dut_i (
        .FCLK      (FCLK),
        .reset     (reset),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_k      (rx_k),
        .rx_valid  (rx_valid),
        .rx_err    (rx_err),
        .locked    (locked)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic shift_word(input rx_pkg::word_t w);
        for (int i = rx_pkg::word_bits - 1; i >= 0; i--)
        begin
            @(negedge FCLK);
            serial_in = w[i];   // a goes first
        end
    endtask

    task automatic send_symbol(input rx_pkg::byte_t d, input logic k);
        rx_pkg::word_t w;
        logic          rd_nxt;
        w     = encode_8b10b(d, k, tx_rd, rd_nxt);
        tx_rd = rd_nxt;
        if (!(k && d == k28_1))
            exp_q.push_back({k, d});
        shift_word(w);
    endtask

    // commas until lock is seen lost (if it was held) and then regained
    task automatic wait_for_lock(input int min_words);
        int   n;
        logic saw_low;
        n       = 0;
        saw_low = !locked;
        while ((n < min_words || !(saw_low && locked)) && n < max_lock_words)
        begin
            send_symbol(k28_1, 1'b1);
            if (!locked)
                saw_low = 1'b1;
            n++;
        end
        assert (saw_low && locked)
        else fail_run($sformatf("no lock within %0d comma words", max_lock_words));
    endtask

    task automatic send_traffic(input int n_data);
        rx_pkg::byte_t ctrl [4];
        int            count;
        logic [31:0]   r;
        ctrl  = '{8'hBC, 8'hFB, 8'h1C, 8'hF7};   // K28.5 K27.7 K28.0 K23.7
        count = 0;
        while (count < n_data)
        begin
            r = $random(seed);
            if (r[2:0] == 3'd0)
            begin
                send_symbol(ctrl[r[4:3]], 1'b1);
            end
            else
            begin
                send_symbol(r[15:8], 1'b0);
                count++;
            end
        end
    endtask

    always @(posedge FCLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
            fail_run($sformatf("timeout after %0d cycles", cycle_cnt));
    end

    always @(negedge FCLK)
    begin
        logic [8:0] exp;
        if (!reset && rx_err)
        begin
            assert (rx_valid) else fail_run("rx_err without rx_valid");
            assert (errs_expected > 0) else fail_run("unexpected rx_err");
            errs_expected = errs_expected - 1;
        end
        else if (!reset && rx_valid && !(rx_k && rx_data == k28_1))
        begin
            assert (exp_q.size() > 0) else fail_run("rx_valid with no word expected");
            exp = exp_q.pop_front();
            assert (rx_data == exp[7:0])
            else fail_run($sformatf("MISMATCH t=%0t rx_data got %h exp %h",
                                    $time, rx_data, exp[7:0]));
            assert (rx_k == exp[8])
            else fail_run($sformatf("MISMATCH t=%0t rx_k got %b exp %b",
                                    $time, rx_k, exp[8]));
        end
    end

    task automatic idle_check();
        assert (!locked && !rx_valid && !rx_err)
        else fail_run("locked, rx_valid or rx_err high before any comma");
    endtask

    initial
    begin
        int            filler;
        rx_pkg::word_t bad;
        logic          rd_dummy;
        serial_in     = 1'b0;
        seed          = 32'h7e43;
        tx_rd         = 1'b0;
        errs_expected = 0;
        cycle_cnt     = 0;

        @(negedge FCLK);
        while (reset)
            @(negedge FCLK);

        repeat (20)
        begin
            @(negedge FCLK);
            serial_in = 1'b0;
            idle_check();
        end
        filler = $unsigned($random(seed)) % 10;   // random bit offset
        repeat (filler)
        begin
            @(negedge FCLK);
            serial_in = $random(seed);
            idle_check();
        end

        wait_for_lock(16);
        send_traffic(200);

        // invalid 6b sub-block
        errs_expected = errs_expected + 1;
        shift_word(10'b111111_0100);
        wait_for_lock(0);
        send_traffic(40);

        // D.0 in the form that breaks running disparity
        errs_expected = errs_expected + 1;
        bad = encode_8b10b(8'h00, 1'b0, !tx_rd, rd_dummy);
        shift_word(bad);
        wait_for_lock(0);
        send_traffic(40);

        repeat (4) send_symbol(k28_1, 1'b1);   // flush the pipeline
        repeat (4) @(negedge FCLK);

        if (exp_q.size() == 0 && errs_expected == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("%0d words never arrived, %0d errors never seen",
                     exp_q.size(), errs_expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

/* serial_rx_checker.sv */
`timescale 1ns/1ps

module serial_rx_checker (
    input logic FCLK,
    input logic reset,
    input logic bitslip,
    input logic locked,
    input logic dec_err
);

    slip_one_cycle: assert property (@(posedge FCLK) disable iff (reset)
        bitslip |=> !bitslip)
        else $error("bitslip held for more than one cycle");

    no_slip_locked: assert property (@(posedge FCLK) disable iff (reset)
        !(bitslip && locked))
        else $error("bitslip while locked");

    err_drops_lock: assert property (@(posedge FCLK) disable iff (reset)
        (locked && dec_err) |=> !locked)
        else $error("locked did not fall after a decode error");

endmodule

bind word_align_fsm serial_rx_checker chk_i (
    .FCLK    (FCLK),
    .reset   (reset),
    .bitslip (bitslip),
    .locked  (locked),
    .dec_err (dec_err)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 16
) (
    output logic FCLK,
    output logic reset
);

    initial
    begin
        FCLK  = 1'b0;
        reset = 1'b1;
        forever #(period_ns / 2.0) FCLK = ~FCLK;
    end

    initial
    begin
        repeat (reset_cycles) @(posedge FCLK);
        @(negedge FCLK);
        reset = 1'b0;   // released on a falling edge like every other input
    end

endmodule

/* serial_rx.sv */
`timescale 1ns/1ps

module serial_rx (
    input  logic          FCLK,
    input  logic          reset,
    input  logic          serial_in,
    output rx_pkg::byte_t rx_data,
    output logic          rx_k,
    output logic          rx_valid,
    output logic          rx_err,
    output logic          locked
);

    rx_pkg::word_t word;
    logic          word_stb;
    logic          bitslip;
    rx_pkg::byte_t dec_byte;
    logic          dec_k;
    logic          dec_err;
    logic          dec_stb;

    deser_bitslip deser_i (
        .FCLK      (FCLK),
        .reset     (reset),
        .serial_in (serial_in),
        .bitslip   (bitslip),
        .word      (word),
        .word_stb  (word_stb)
    );

    word_align_fsm align_i (
        .FCLK     (FCLK),
        .reset    (reset),
        .word     (word),
        .word_stb (word_stb),
        .dec_err  (dec_err),
        .bitslip  (bitslip),
        .locked   (locked)
    );

    dec_8b10b dec_i (
        .FCLK     (FCLK),
        .reset    (reset),
        .word     (word),
        .word_stb (word_stb),
        .dec_byte (dec_byte),
        .dec_k    (dec_k),
        .dec_err  (dec_err),
        .dec_stb  (dec_stb)
    );

    assign rx_data  = dec_byte;
    assign rx_k     = dec_k;
    assign rx_valid = dec_stb & locked;   // nothing leaves while searching
    assign rx_err   = dec_err & locked;   // locked still high on the bad word

endmodule

/* dec_8b10b.sv */
`timescale 1ns/1ps

module dec_8b10b (
    input  logic          FCLK,
    input  logic          reset,
    input  rx_pkg::word_t word,
    input  logic          word_stb,
    output rx_pkg::byte_t dec_byte,
    output logic          dec_k,
    output logic          dec_err,
    output logic          dec_stb
);

    rx_pkg::sb6_t sb6;
    rx_pkg::sb4_t sb4;
    rx_pkg::sb4_t sb4_val;   // fghj as looked up
    logic [4:0]   edcba;
    logic [2:0]   hgf;
    logic [2:0]   ones6;
    logic [2:0]   ones4;
    logic         valid6;
    logic         valid4;
    logic         is_k28;
    logic         is_a7;
    logic         is_k;
    logic         a7_ok;
    logic         rd;        // running disparity, 1 is positive
    logic         rd6;
    logic         rd_next;
    logic         disp_err;
    logic         code_err;

    assign sb6 = word[9:4];
    assign sb4 = word[3:0];

    assign ones6 = 3'($countones(sb6));
    assign ones4 = 3'($countones(sb4));

    assign is_k28 = (sb6 == rx_pkg::k28_6b_pos) || (sb6 == rx_pkg::k28_6b_neg);

    // K28 in its negative form uses the complemented 4b table
    assign sb4_val = (sb6 == rx_pkg::k28_6b_neg) ? ~sb4 : sb4;

    always_comb
    begin
        valid6 = 1'b1;
        case (sb6)
            6'b100111, 6'b011000:        edcba = 5'd0;
            6'b011101, 6'b100010:        edcba = 5'd1;
            6'b101101, 6'b010010:        edcba = 5'd2;
            6'b110001:                   edcba = 5'd3;
            6'b110101, 6'b001010:        edcba = 5'd4;
            6'b101001:                   edcba = 5'd5;
            6'b011001:                   edcba = 5'd6;
            rx_pkg::d07_6b_hi, rx_pkg::d07_6b_lo: edcba = 5'd7;
            6'b111001, 6'b000110:        edcba = 5'd8;
            6'b100101:                   edcba = 5'd9;
            6'b010101:                   edcba = 5'd10;
            6'b110100:                   edcba = 5'd11;
            6'b001101:                   edcba = 5'd12;
            6'b101100:                   edcba = 5'd13;
            6'b011100:                   edcba = 5'd14;
            6'b010111, 6'b101000:        edcba = 5'd15;
            6'b011011, 6'b100100:        edcba = 5'd16;
            6'b100011:                   edcba = 5'd17;
            6'b010011:                   edcba = 5'd18;
            6'b110010:                   edcba = 5'd19;
            6'b001011:                   edcba = 5'd20;
            6'b101010:                   edcba = 5'd21;
            6'b011010:                   edcba = 5'd22;
            6'b111010, 6'b000101:        edcba = 5'd23;
            6'b110011, 6'b001100:        edcba = 5'd24;
            6'b100110:                   edcba = 5'd25;
            6'b010110:                   edcba = 5'd26;
            6'b110110, 6'b001001:        edcba = 5'd27;
            6'b001110:                   edcba = 5'd28;
            6'b101110, 6'b010001:        edcba = 5'd29;
            6'b011110, 6'b100001:        edcba = 5'd30;
            6'b101011, 6'b010100:        edcba = 5'd31;
            rx_pkg::k28_6b_pos, rx_pkg::k28_6b_neg: edcba = 5'd28;
            default:
            begin
                edcba  = 5'd0;
                valid6 = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        valid4 = 1'b1;
        is_a7  = 1'b0;
        case (sb4_val)
            4'b1011, 4'b0100:                   hgf = 3'd0;
            4'b1001:                            hgf = 3'd1;
            4'b0101:                            hgf = 3'd2;
            rx_pkg::dx3_4b_hi, rx_pkg::dx3_4b_lo: hgf = 3'd3;
            4'b1101, 4'b0010:                   hgf = 3'd4;
            4'b1010:                            hgf = 3'd5;
            4'b0110:                            hgf = 3'd6;
            4'b1110, 4'b0001:                   hgf = 3'd7;
            rx_pkg::dxa7_4b_hi, rx_pkg::dxa7_4b_lo:
            begin
                hgf   = 3'd7;
                is_a7 = 1'b1;
            end
            default:
            begin
                hgf    = 3'd0;
                valid4 = 1'b0;
            end
        endcase
    end

    // A7 marks K23/27/29/30.7, and data only for x = 11, 13, 14, 17, 18, 20
    assign is_k  = is_k28 || (is_a7 && (edcba == 5'd23 || edcba == 5'd27
                                     || edcba == 5'd29 || edcba == 5'd30));
    assign a7_ok = !is_a7 || is_k || edcba == 5'd11 || edcba == 5'd13
                || edcba == 5'd14 || edcba == 5'd17 || edcba == 5'd18 || edcba == 5'd20;

    // the rd that follows each sub-block comes from the code itself,
    // so a bad word also resyncs rd to the word's own disparity
    always_comb
    begin
        disp_err = 1'b0;
        rd6      = rd;
        if (ones6 > 3'd3)
        begin
            rd6      = 1'b1;
            disp_err = rd;
        end
        else if (ones6 < 3'd3)
        begin
            rd6      = 1'b0;
            disp_err = !rd;
        end
        else if (sb6 == rx_pkg::d07_6b_hi)
        begin
            disp_err = rd;
        end
        else if (sb6 == rx_pkg::d07_6b_lo)
        begin
            disp_err = !rd;
        end

        rd_next = rd6;
        if (ones4 > 3'd2)
        begin
            rd_next  = 1'b1;
            disp_err = disp_err | rd6;
        end
        else if (ones4 < 3'd2)
        begin
            rd_next  = 1'b0;
            disp_err = disp_err | !rd6;
        end
        else if (sb4 == rx_pkg::dx3_4b_hi)
        begin
            disp_err = disp_err | rd6;
        end
        else if (sb4 == rx_pkg::dx3_4b_lo)
        begin
            disp_err = disp_err | !rd6;
        end
    end

    assign code_err = !valid6 || !valid4 || !a7_ok;

    always_ff @(posedge FCLK)
    begin
        if (reset)
        begin
            rd      <= 1'b0;
            dec_stb <= 1'b0;
            dec_err <= 1'b0;
        end
        else
        begin
            dec_stb <= word_stb;
            dec_err <= word_stb & (code_err | disp_err);
            if (word_stb)
            begin
                rd <= rd_next;
            end
        end
    end

    always_ff @(posedge FCLK)
    begin
        if (word_stb)
        begin
            dec_byte <= {hgf, edcba};
            dec_k    <= is_k;
        end
    end

endmodule

/* word_align_fsm.sv */
`timescale 1ns/1ps

module word_align_fsm (
    input  logic          FCLK,
    input  logic          reset,
    input  rx_pkg::word_t word,
    input  logic          word_stb,
    input  logic          dec_err,
    output logic          bitslip,
    output logic          locked
);

    rx_pkg::align_state_e state;
    rx_pkg::word_t        prev_word;
    logic [1:0]           wait_cnt;
    logic                 comma_pair;
    logic                 wait_done;

    // K28.1 pair of opposite disparity, either order
    assign comma_pair = (word == rx_pkg::k28_1_pos && prev_word == rx_pkg::k28_1_neg)
                     || (word == rx_pkg::k28_1_neg && prev_word == rx_pkg::k28_1_pos);

    assign wait_done = (wait_cnt == 2'(rx_pkg::wait_words - 1));

    assign bitslip = (state == rx_pkg::BITSHIFT);   // BITSHIFT lasts one cycle

    always_ff @(posedge FCLK)
    begin
        if (word_stb)
        begin
            prev_word <= word;
        end
    end

    always_ff @(posedge FCLK)
    begin
        if (reset)
        begin
            state    <= rx_pkg::START;
            wait_cnt <= 2'd0;
            locked   <= 1'b0;
        end
        else
        begin
            case (state)
                rx_pkg::START:
                begin
                    if (word_stb)
                    begin
                        state    <= rx_pkg::WAIT;
                        wait_cnt <= 2'd0;
                    end
                end
                rx_pkg::WAIT:
                begin
                    if (word_stb)
                    begin
                        if (wait_done)
                        begin
                            state <= rx_pkg::CHECK;
                        end
                        else
                        begin
                            wait_cnt <= wait_cnt + 2'd1;
                        end
                    end
                end
                rx_pkg::CHECK:
                begin
                    if (word_stb)
                    begin
                        if (comma_pair)
                        begin
                            state  <= rx_pkg::LOCKED;
                            locked <= 1'b1;
                        end
                        else
                        begin
                            state <= rx_pkg::BITSHIFT;
                        end
                    end
                end
                rx_pkg::BITSHIFT:
                begin
                    state    <= rx_pkg::WAIT;   // let the new boundary settle
                    wait_cnt <= 2'd0;
                end
                rx_pkg::LOCKED:
                begin
                    if (dec_err)   // only valid with dec_stb
                    begin
                        state    <= rx_pkg::WAIT;
                        wait_cnt <= 2'd0;
                        locked   <= 1'b0;
                    end
                end
                default:
                begin
                    state  <= rx_pkg::START;
                    locked <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* deser_bitslip.sv */
`timescale 1ns/1ps

module deser_bitslip (
    input  logic          FCLK,
    input  logic          reset,
    input  logic          serial_in,
    input  logic          bitslip,
    output rx_pkg::word_t word,
    output logic          word_stb
);

    localparam int unsigned nb = rx_pkg::word_bits;

    rx_pkg::word_t   shift_reg;   // oldest bit ends at the msb
    logic [nb-1:0]   ring;        // one-hot word phase

    always_ff @(posedge FCLK)
    begin
        shift_reg <= {shift_reg[nb-2:0], serial_in};
    end

    // a slip rotates by two, so the tap comes one cycle early;
    // the aligner slips well after the tap, never on ring[nb-1]
    always_ff @(posedge FCLK)
    begin
        if (reset)
        begin
            ring <= {{(nb-1){1'b0}}, 1'b1};
        end
        else if (bitslip)
        begin
            ring <= {ring[nb-3:0], ring[nb-1:nb-2]};
        end
        else
        begin
            ring <= {ring[nb-2:0], ring[nb-1]};
        end
    end

    always_ff @(posedge FCLK)
    begin
        if (reset)
        begin
            word_stb <= 1'b0;
        end
        else
        begin
            word_stb <= ring[0];   // pulse with the new word
        end
    end

    always_ff @(posedge FCLK)
    begin
        if (ring[0])
        begin
            word <= shift_reg;
        end
    end

endmodule

/* rx_pkg.sv */
package rx_pkg;

    localparam int unsigned word_bits = 10;
    localparam int unsigned byte_bits = 8;

    // strobes spent in WAIT after a slip or a lost lock
    localparam int unsigned wait_words = 2;

    typedef logic [word_bits-1:0] word_t;   // abcdei fghj with a at the msb
    typedef logic [byte_bits-1:0] byte_t;   // HGF EDCBA
    typedef logic [5:0]           sb6_t;    // abcdei sub-block
    typedef logic [3:0]           sb4_t;    // fghj sub-block

    // K28.1 in both forms named by the disparity of the word itself
    localparam word_t k28_1_pos = 10'b00_1111_1001;
    localparam word_t k28_1_neg = 10'b11_0000_0110;

    // K28 6b forms
    localparam sb6_t k28_6b_pos = 6'b001111;
    localparam sb6_t k28_6b_neg = 6'b110000;

    // neutral codes that still depend on the running disparity
    localparam sb6_t d07_6b_hi  = 6'b111000;   // only after negative rd
    localparam sb6_t d07_6b_lo  = 6'b000111;   // only after positive rd
    localparam sb4_t dx3_4b_hi  = 4'b1100;     // only after negative rd
    localparam sb4_t dx3_4b_lo  = 4'b0011;     // only after positive rd

    // alternate 7 forms
    localparam sb4_t dxa7_4b_hi = 4'b0111;
    localparam sb4_t dxa7_4b_lo = 4'b1000;

    typedef enum logic [2:0] {
        START,
        WAIT,
        CHECK,
        BITSHIFT,
        LOCKED
    } align_state_e;

endpackage
